/* Makefile */
# Verilator flow for the PSRAM block
TOP := psramBlockTb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f project.f --top-module $(TOP)

# The run passes only if the pass line shows up in the output
sim:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | awk '{ print } /^>>> PASS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

/* project.f */
src/psramPkg.sv
src/psramCsr.sv
src/psramBurstBuf.sv
src/psramSequencer.sv
src/psramBlock.sv
tests/psramModel.sv
tests/psramBlockTb.sv

/* src/psramBlock.sv */
// PSRAM block top
// Register space, burst buffer and pin sequencer
// Write beat grouping, read requests and buffer direction
`timescale 1ns/10ps
module psramBlock
	import psramPkg::*;
(
	input  logic           sysClk,
	input  logic           rstN,
	// Register bus
	input  logic           csrWrEn,
	input  logic           csrRdEn,
	input  csrAddrT        csrAddr,
	input  csrDataT        csrWrData,
	output csrDataT        csrRdData,
	output logic           csrRdValid,
	// Write stream
	input  logic           wrValid,
	input  psramWrBeatT    wrBeat,
	output logic           wrReady,
	// Read request and read stream
	input  logic           rdReqValid,
	input  psramAddrT      rdReqAddr,
	output logic           rdReqReady,
	output logic           rdValid,
	output psramDataT      rdData,
	input  logic           rdReady,
	// Pins
	inout  wire psramDataT psramDq,
	inout  wire [1:0]      psramDqs,
	output logic           psramClk,
	output logic           psramCsN
);

	logic      unitRstN, ramRst, initDone, busy;
	logic      wrBurstDone, rdBurstDone;
	logic      seqBusy, seqCmdReady, seqPop, seqPush;
	psramDataT seqPushData;
	logic      cmdPend;      // Command waiting for the sequencer
	logic      activeRead;   // Buffer belongs to a read until drained
	logic      gathering;    // Write group partly filled
	logic      unitIdle;
	psramCmdT  pendCmd;
	psramAddrT wrBase;       // Aligned address of the group's first beat
	logic      bufPushValid, bufPushReady, bufPopValid, bufPopReady, bufFull;
	psramDataT bufPushData, bufPopData;

	// Register space, all ports share names with this level
	psramCsr csrSpace (.*);

	assign unitRstN = rstN && !ramRst;
	assign busy     = seqBusy || cmdPend || activeRead || gathering;

	// ------------------------------------------------
	// Stream handshakes and buffer direction
	// ------------------------------------------------
	assign unitIdle   = initDone && !seqBusy && !cmdPend && !activeRead;
	assign wrReady    = unitIdle && bufPushReady;
	assign rdReqReady = unitIdle && bufPushReady && !gathering;

	assign bufPushValid = activeRead ? seqPush : (wrValid && wrReady);
	assign bufPushData  = activeRead ? seqPushData : wrBeat.data;
	assign bufPopReady  = activeRead ? rdReady : seqPop;
	assign rdValid      = activeRead && bufPopValid;
	assign rdData       = bufPopData;

	always_ff @(posedge sysClk)
	begin
		if (!unitRstN)
		begin
			cmdPend    <= 1'b0;
			activeRead <= 1'b0;
			gathering  <= 1'b0;
		end
		else
		begin
			if (cmdPend && seqCmdReady)
				cmdPend <= 1'b0;
			else if ((rdReqValid && rdReqReady) || (gathering && bufFull))
				cmdPend <= 1'b1;
			if (wrValid && wrReady && !gathering)
				gathering <= 1'b1;                // First beat opens the group
			else if (gathering && bufFull)
				gathering <= 1'b0;                // Handed over as a write command
			if (rdReqValid && rdReqReady)
				activeRead <= 1'b1;
			else if (activeRead && !cmdPend && !seqBusy && !bufFull)
				activeRead <= 1'b0;               // Last word taken by the stream
		end
	end

	// Command payload and group address
	always_ff @(posedge sysClk)
	begin
		if (wrValid && wrReady && !gathering)
			wrBase <= burstAlign(wrBeat.addr);
		if (rdReqValid && rdReqReady)
			pendCmd <= '{isWrite: 1'b0, addr: burstAlign(rdReqAddr)};
		else if (gathering && bufFull)
			pendCmd <= '{isWrite: 1'b1, addr: wrBase};
	end

	// ------------------------------------------------
	// Buffer and sequencer
	// ------------------------------------------------
	psramBurstBuf burstBuf (
		.sysClk,
		.rstN,
		.clear     (ramRst),
		.pushValid (bufPushValid),
		.pushData  (bufPushData),
		.pushReady (bufPushReady),
		.popValid  (bufPopValid),
		.popData   (bufPopData),
		.popReady  (bufPopReady),
		.full      (bufFull)
	);

	psramSequencer sequencer (
		.sysClk,
		.rstN        (unitRstN),
		.cmdValid    (cmdPend),
		.cmd         (pendCmd),
		.cmdReady    (seqCmdReady),
		.bufData     (bufPopData),
		.bufPop      (seqPop),
		.bufPush     (seqPush),
		.bufPushData (seqPushData),
		.initDone,
		.busy        (seqBusy),
		.wrBurstDone,
		.rdBurstDone,
		.psramClk,
		.psramCsN,
		.psramDq,
		.psramDqs
	);

endmodule

/* src/psramBurstBuf.sv */
// Eight-word burst buffer
// Fills to full, then drains to empty, shared by both directions
`timescale 1ns/10ps
module psramBurstBuf
	import psramPkg::*;
(
	input  logic      sysClk,
	input  logic      rstN,
	input  logic      clear,         // Drops a partial or pending burst
	// Fill side
	input  logic      pushValid,
	input  psramDataT pushData,
	output logic      pushReady,
	// Drain side
	output logic      popValid,
	output psramDataT popData,
	input  logic      popReady,
	output logic      full
);

	psramDataT mem [BurstLen];
	beatIdxT   wrPtr;
	beatIdxT   rdPtr;
	logic      pushFire;
	logic      popFire;

	assign pushReady = !full;       // No pushes while draining
	assign popValid  = full;
	assign popData   = mem[rdPtr];  // Head word, held until popped
	assign pushFire  = pushValid && pushReady;
	assign popFire   = popValid && popReady;

	// ------------------------------------------------
	// Storage
	// ------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (pushFire)
			mem[wrPtr] <= pushData;
	end

	// Pointers wrap back to zero at the end of each burst
	always_ff @(posedge sysClk)
	begin
		if (!rstN || clear)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			full  <= 1'b0;
		end
		else
		begin
			if (pushFire)
			begin
				wrPtr <= wrPtr + 1'b1;
				if (wrPtr == LastBeat)
					full <= 1'b1;       // Set on the 8th beat
			end
			if (popFire)
			begin
				rdPtr <= rdPtr + 1'b1;
				if (rdPtr == LastBeat)
					full <= 1'b0;
			end
		end
	end

endmodule

/* src/psramCsr.sv */
// Register space of the PSRAM block
// Block address decode, soft reset bit, status and burst counters
`timescale 1ns/10ps
module psramCsr
	import psramPkg::*;
(
	input  logic    sysClk,
	input  logic    rstN,
	// Register bus
	input  logic    csrWrEn,
	input  logic    csrRdEn,
	input  csrAddrT csrAddr,
	input  csrDataT csrWrData,
	output csrDataT csrRdData,
	output logic    csrRdValid,
	// Unit side
	input  logic    initDone,
	input  logic    busy,
	input  logic    wrBurstDone,     // One pulse per finished burst
	input  logic    rdBurstDone,
	output logic    ramRst           // Soft reset, active high
);

	logic    blockHit;
	csrOffsT regOffs;
	csrDataT wrCount;
	csrDataT rdCount;
	csrDataT rdMux;

	// ------------------------------------------------
	// Decode
	// ------------------------------------------------
	assign blockHit = csrAddr[$bits(csrAddrT)-1 -: BlockAdrsMap] == BlockBase;
	assign regOffs  = csrAddr[CsrOffsW-1:0];

	always_comb
	begin
		case (regOffs)
			RegCtrl:    rdMux = {31'd0, ramRst};
			RegStatus:  rdMux = {30'd0, busy, initDone};
			RegWrCount: rdMux = wrCount;
			RegRdCount: rdMux = rdCount;
			default:    rdMux = '0;     // Unmapped offsets read zero
		endcase
	end

	// ------------------------------------------------
	// Control bit and counters
	// ------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			ramRst     <= 1'b0;
			wrCount    <= '0;
			rdCount    <= '0;
			csrRdValid <= 1'b0;
		end
		else
		begin
			if (csrWrEn && blockHit && regOffs == RegCtrl)
				ramRst <= csrWrData[0];
			if (wrBurstDone)
				wrCount <= wrCount + 1'b1;
			if (rdBurstDone)
				rdCount <= rdCount + 1'b1;
			csrRdValid <= csrRdEn && blockHit;  // Misses stay silent
		end
	end

	// Read word, one cycle after the enable
	always_ff @(posedge sysClk)
	begin
		if (csrRdEn && blockHit)
			csrRdData <= rdMux;
	end

endmodule

/* src/psramPkg.sv */
// Shared widths, typedefs and structs of the PSRAM block
// Pin command codes, burst timing and register map
package psramPkg;

	// ------------------------------------------------
	// Widths
	// ------------------------------------------------
	typedef logic [15:0] psramDataT;    // One PSRAM word
	typedef logic [23:0] psramAddrT;    // Word address
	typedef logic [15:0] csrAddrT;      // Register bus address
	typedef logic [31:0] csrDataT;      // Register word

	// Block position on the register bus
	localparam int BlockAdrsMap = 8;                      // Upper bits that select a block
	localparam logic [BlockAdrsMap-1:0] BlockBase = 8'h08;
	localparam int CsrOffsW = $bits(csrAddrT) - BlockAdrsMap;
	typedef logic [CsrOffsW-1:0] csrOffsT;                // Offset inside the block

	// ------------------------------------------------
	// Burst and pin timing, in pin clocks
	// ------------------------------------------------
	localparam int BurstLen = 8;
	localparam int ReadWait = 4;        // Address to first read word
	localparam int InitWait = 64;       // Power-up wait before the reset command
	typedef logic [$clog2(BurstLen)-1:0] beatIdxT;
	typedef logic [$clog2(InitWait)-1:0] waitCntT;
	localparam beatIdxT LastBeat = beatIdxT'(BurstLen - 1);

	// Pin command words
	localparam psramDataT CmdRead  = 16'h00A0;
	localparam psramDataT CmdWrite = 16'h0020;
	localparam psramDataT CmdReset = 16'h00FF;

	// Register offsets
	localparam csrOffsT RegCtrl    = csrOffsT'('h0);  // Bit 0 soft reset
	localparam csrOffsT RegStatus  = csrOffsT'('h4);  // Bit 0 initDone, bit 1 busy
	localparam csrOffsT RegWrCount = csrOffsT'('h8);
	localparam csrOffsT RegRdCount = csrOffsT'('hC);

	// ------------------------------------------------
	// Structs and state
	// ------------------------------------------------
	typedef struct packed {
		psramAddrT addr;
		psramDataT data;
	} psramWrBeatT;

	typedef struct packed {
		logic      isWrite;
		psramAddrT addr;                // Already aligned to a burst
	} psramCmdT;

	typedef enum logic [3:0] {
		sInitWait, sResetCmd, sIdle, sCmd, sAddrHi, sAddrLo, sWait, sData, sDone
	} seqStateT;

	// Round an address down to its burst start
	function automatic psramAddrT burstAlign(input psramAddrT addr);
		return addr & ~psramAddrT'(BurstLen - 1);
	endfunction

endpackage

/* src/psramSequencer.sv */
// PSRAM pin-side sequencer
// Power-up wait, reset command, then one 8-word burst at a time
// Pin clock is sysClk / 2, outputs move while psramClk is low
`timescale 1ns/10ps
module psramSequencer
	import psramPkg::*;
(
	input  logic           sysClk,
	input  logic           rstN,
	// Command from the block top
	input  logic           cmdValid,
	input  psramCmdT       cmd,
	output logic           cmdReady,
	// Burst buffer
	input  psramDataT      bufData,        // Head word for write bursts
	output logic           bufPop,
	output logic           bufPush,
	output psramDataT      bufPushData,
	// Status
	output logic           initDone,
	output logic           busy,
	output logic           wrBurstDone,
	output logic           rdBurstDone,
	// Pins
	output logic           psramClk,
	output logic           psramCsN,
	inout  wire psramDataT psramDq,
	inout  wire [1:0]      psramDqs
);

	seqStateT  state;
	psramCmdT  cmdReg;      // Command being served
	waitCntT   waitCnt;     // Init and read wait
	beatIdxT   beatCnt;     // Data beats
	logic      tick;        // Last sysClk of a pin clock
	logic      sample;      // Rising edge of the pin clock
	logic      wrPhase;
	logic      rdPhase;
	psramDataT dqOut;
	logic [1:0] dqsOut;

	assign tick    = psramClk;
	assign sample  = !psramClk;
	assign wrPhase = state == sData && cmdReg.isWrite;
	assign rdPhase = state == sData && !cmdReg.isWrite;

	// ------------------------------------------------
	// Handshakes and status
	// ------------------------------------------------
	assign cmdReady    = state == sIdle && tick;
	assign initDone    = !(state inside {sInitWait, sResetCmd});
	assign busy        = state != sIdle;
	assign bufPop      = wrPhase && tick;       // Word leaves at the end of its pin clock
	assign bufPush     = rdPhase && sample && psramDqs == 2'b11;
	assign bufPushData = psramDq;
	assign wrBurstDone = state == sDone && tick && cmdReg.isWrite;
	assign rdBurstDone = state == sDone && tick && !cmdReg.isWrite;

	// ------------------------------------------------
	// Pin drive
	// ------------------------------------------------
	assign psramCsN = state inside {sInitWait, sIdle, sDone};

	always_comb
	begin
		case (state)
			sResetCmd: dqOut = CmdReset;
			sCmd:      dqOut = cmdReg.isWrite ? CmdWrite : CmdRead;
			sAddrHi:   dqOut = {8'h00, cmdReg.addr[23:16]};
			sAddrLo:   dqOut = cmdReg.addr[15:0];
			sData:     dqOut = bufData;
			default:   dqOut = '0;
		endcase
	end

	assign dqsOut   = wrPhase ? 2'b11 : 2'b00;     // Strobe marks write data
	assign psramDq  = rdPhase ? 'z : dqOut;        // Device owns the bus on read data
	assign psramDqs = rdPhase ? 2'bzz : dqsOut;

	// ------------------------------------------------
	// FSM, steps once per pin clock
	// ------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			psramClk <= 1'b0;
			state    <= sInitWait;
			waitCnt  <= '0;
			beatCnt  <= '0;
		end
		else
		begin
			psramClk <= !psramClk;
			if (tick)
			begin
				case (state)
					sInitWait:
					begin
						if (waitCnt == waitCntT'(InitWait - 1))
						begin
							waitCnt <= '0;
							state   <= sResetCmd;
						end
						else
							waitCnt <= waitCnt + 1'b1;
					end
					sResetCmd: state <= sIdle;
					sIdle:
					begin
						if (cmdValid)
							state <= sCmd;
					end
					sCmd:      state <= sAddrHi;
					sAddrHi:   state <= sAddrLo;
					sAddrLo:   state <= cmdReg.isWrite ? sData : sWait;
					sWait:
					begin
						if (waitCnt == waitCntT'(ReadWait - 1))
						begin
							waitCnt <= '0;
							state   <= sData;
						end
						else
							waitCnt <= waitCnt + 1'b1;
					end
					sData:
					begin
						beatCnt <= beatCnt + 1'b1;  // Wraps to zero after the last beat
						if (beatCnt == LastBeat)
							state <= sDone;
					end
					sDone:     state <= sIdle;
					default:   state <= sIdle;
				endcase
			end
		end
	end

	// Command capture on accept
	always_ff @(posedge sysClk)
	begin
		if (cmdValid && cmdReady)
			cmdReg <= cmd;
	end

endmodule

/* tests/psramBlockTb.sv */
// Testbench for the PSRAM block
// Clock, reset, LCG stimulus, register bus and stream tasks
// Concurrent assertions against a scoreboard of written words
`timescale 1ns/10ps
module psramBlockTb
	import psramPkg::*;
();

	localparam int StatusPolls = 200;    // RegStatus reads before giving up
	localparam int StepLimit   = 400;    // Cycles for one handshake or stream

	logic        sysClk;
	logic        rstN;
	logic        csrWrEn, csrRdEn;
	csrAddrT     csrAddr;
	csrDataT     csrWrData;
	csrDataT     csrRdData;
	logic        csrRdValid;
	logic        wrValid, wrReady;
	psramWrBeatT wrBeat;
	logic        rdReqValid, rdReqReady;
	psramAddrT   rdReqAddr;
	logic        rdValid, rdReady;
	psramDataT   rdData;
	wire [15:0]  psramDq;
	wire [1:0]   psramDqs;
	logic        psramClk, psramCsN;

	logic [31:0] lcgState = 32'h6274;
	psramDataT   scoreboard [4096];        // Mirror of written words
	psramAddrT   rdBase = '0;              // Start of the burst being read
	logic [3:0]  rdBeats;                  // Beats taken since the request
	psramDataT   expWord;
	int          expWrBursts;
	int          expRdBursts;

	psramBlock dut (.*);
	psramModel ram (.psramClk, .psramCsN, .psramDq, .psramDqs);

	initial
	begin
		sysClk = 1'b0;
		forever #2 sysClk = ~sysClk;       // 4 ns period
	end

	task automatic stopWithFail(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// ------------------------------------------------
	// Read-side reference
	// ------------------------------------------------
	always @(posedge sysClk)
	begin
		if (!rstN)
			rdBeats <= 4'd8;                   // No burst owed
		else if (rdReqValid && rdReqReady)
		begin
			rdBase  <= {rdReqAddr[23:3], 3'b000};  // Aligned down to 8
			rdBeats <= 4'd0;
		end
		else if (rdValid && rdReady)
			rdBeats <= rdBeats + 4'd1;
	end

	assign expWord = scoreboard[rdBase[11:0] + 12'(rdBeats[2:0])];

	// ------------------------------------------------
	// Assertions
	// ------------------------------------------------
	resetQuiet: assert property (@(posedge sysClk) $past(!rstN)
		|-> psramCsN && !psramClk && !rdValid && !wrReady && !rdReqReady && !csrRdValid)
	else
		stopWithFail($sformatf(
		"[ERROR] reset psramCsN %h psramClk %h rdValid %h wrReady %h rdReqReady %h csrRdValid %h",
			$sampled(psramCsN), $sampled(psramClk), $sampled(rdValid), $sampled(wrReady),
			$sampled(rdReqReady), $sampled(csrRdValid)));

	// Streams closed before init and while the pins are busy
	readyGate: assert property (@(posedge sysClk) disable iff (!rstN)
		!dut.initDone || dut.seqBusy |-> !wrReady && !rdReqReady)
	else
		stopWithFail($sformatf("[ERROR] wrReady %h rdReqReady %h initDone %h",
			$sampled(wrReady), $sampled(rdReqReady), $sampled(dut.initDone)));

	csrTiming: assert property (@(posedge sysClk) disable iff (!rstN)
		csrRdValid == $past(csrRdEn && csrAddr[15 -: BlockAdrsMap] == BlockBase))
	else
		stopWithFail($sformatf("[ERROR] csrRdValid %h", $sampled(csrRdValid)));

	readData: assert property (@(posedge sysClk) disable iff (!rstN)
		rdValid && rdReady |-> rdData == expWord)
	else
		stopWithFail($sformatf("[ERROR] rdData beat %h exp %h got %h",
			$sampled(rdBeats), $sampled(expWord), $sampled(rdData)));

	beatLimit: assert property (@(posedge sysClk) disable iff (!rstN)
		rdValid |-> rdBeats < 4'd8)
	else
		stopWithFail($sformatf("[ERROR] rdValid %h after beat count %h",
			$sampled(rdValid), $sampled(rdBeats)));

	stallHold: assert property (@(posedge sysClk) disable iff (!rstN)
		$past(rdValid && !rdReady) |-> rdValid && rdData == $past(rdData))
	else
		stopWithFail($sformatf("[ERROR] stalled rdValid %h rdData %h",
			$sampled(rdValid), $sampled(rdData)));

	// ------------------------------------------------
	// Register bus
	// ------------------------------------------------
	task automatic csrWrite(input csrOffsT offs, input csrDataT data);
		csrWrEn   <= 1'b1;
		csrAddr   <= {BlockBase, offs};
		csrWrData <= data;
		@(posedge sysClk);
		csrWrEn <= 1'b0;
	endtask

	task automatic csrRead(input csrAddrT addr, output csrDataT data);
		int n;
		n = 0;
		csrRdEn <= 1'b1;
		csrAddr <= addr;
		@(posedge sysClk);
		csrRdEn <= 1'b0;
		@(posedge sysClk);
		while (!csrRdValid)
		begin
			n++;
			if (n == 4)
				stopWithFail("No csrRdValid after a register read");
			@(posedge sysClk);
		end
		data = csrRdData;
	endtask

	task automatic expectReg(input csrOffsT offs, input csrDataT mask, input csrDataT exp,
		input string name);
		csrDataT got;
		csrRead({BlockBase, offs}, got);
		assert ((got & mask) == exp)
		else
			stopWithFail($sformatf("[ERROR] %s exp %h got %h", name, exp, got & mask));
	endtask

	task automatic waitStatus(input int bitIdx, input logic want, input string what);
		csrDataT st;
		int n;
		n = 0;
		csrRead({BlockBase, RegStatus}, st);
		while (st[bitIdx] != want)
		begin
			n++;
			if (n == StatusPolls)
				stopWithFail({"Timed out waiting for ", what});
			csrRead({BlockBase, RegStatus}, st);
		end
	endtask

	// Another block's address must stay silent
	task automatic missRead();
		csrRdEn <= 1'b1;
		csrAddr <= {BlockBase + 8'd1, RegStatus};
		@(posedge sysClk);
		csrRdEn <= 1'b0;
		repeat (4)
		begin
			@(posedge sysClk);
			assert (!csrRdValid)
			else
				stopWithFail($sformatf("[ERROR] csrRdValid %h on a miss", csrRdValid));
		end
	endtask

	// ------------------------------------------------
	// Streams
	// ------------------------------------------------
	task automatic writeBurst(input psramAddrT addr);
		psramAddrT   base;
		psramWrBeatT beat;
		logic [31:0] r;
		int          n;
		base = {addr[23:3], 3'b000};
		for (int i = 0; i < BurstLen; i++)
		begin
			r = nextRand();
			beat.addr = (i == 0) ? addr : psramAddrT'(r);  // Only the first counts
			r = nextRand();
			beat.data = psramDataT'(r >> 12);
			scoreboard[base[11:0] + 12'(i)] = beat.data;
			wrValid <= 1'b1;
			wrBeat  <= beat;
			n = 0;
			@(posedge sysClk);
			while (!wrReady)
			begin
				n++;
				if (n == StepLimit)
					stopWithFail("Timed out waiting for wrReady");
				@(posedge sysClk);
			end
		end
		wrValid <= 1'b0;
		expWrBursts++;
		expectReg(RegStatus, 32'h2, 32'h2, "RegStatus busy after a write burst");
		waitStatus(1, 1'b0, "busy to clear after a write burst");
	endtask

	task automatic readBurst(input psramAddrT addr, input logic stalls);
		logic [31:0] r;
		int          n;
		int          got;
		n = 0;
		got = 0;
		rdReqValid <= 1'b1;
		rdReqAddr  <= addr;
		@(posedge sysClk);
		while (!rdReqReady)
		begin
			n++;
			if (n == StepLimit)
				stopWithFail("Timed out waiting for rdReqReady");
			@(posedge sysClk);
		end
		rdReqValid <= 1'b0;
		n = 0;
		while (got < BurstLen)
		begin
			r = nextRand();
			rdReady <= stalls ? r[17] : 1'b1;      // Random back-pressure
			@(posedge sysClk);
			if (rdValid && rdReady)
				got++;
			n++;
			if (n == StepLimit)
				stopWithFail("Timed out waiting for eight read beats");
		end
		rdReady <= 1'b0;
		expRdBursts++;
		waitStatus(1, 1'b0, "busy to clear after a read burst");
	endtask

	// ------------------------------------------------
	// Test sequence
	// ------------------------------------------------
	initial
	begin
		rstN        = 1'b0;
		csrWrEn     = 1'b0;
		csrRdEn     = 1'b0;
		csrAddr     = '0;
		csrWrData   = '0;
		wrValid     = 1'b0;
		wrBeat      = '0;
		rdReqValid  = 1'b0;
		rdReqAddr   = '0;
		rdReady     = 1'b0;
		expWrBursts = 0;
		expRdBursts = 0;
		repeat (3) @(posedge sysClk);
		rstN <= 1'b1;
		@(posedge sysClk);

		expectReg(RegStatus, 32'h1, 32'h0, "RegStatus initDone after reset");
		waitStatus(0, 1'b1, "initDone after reset");

		writeBurst(24'h000123);
		writeBurst(24'h000A47);
		readBurst(24'h000A40, 1'b0);               // Reverse order
		readBurst(24'h000125, 1'b1);
		expectReg(RegWrCount, '1, csrDataT'(expWrBursts), "RegWrCount");
		expectReg(RegRdCount, '1, csrDataT'(expRdBursts), "RegRdCount");
		missRead();

		// Soft reset drops initDone one cycle after the write
		csrWrite(RegCtrl, 32'h1);
		@(posedge sysClk);
		expectReg(RegStatus, 32'h1, 32'h0, "RegStatus initDone in soft reset");
		csrWrite(RegCtrl, 32'h0);
		waitStatus(0, 1'b1, "initDone after soft reset");

		readBurst(24'h000122, 1'b1);               // Contents survive the soft reset
		readBurst(24'h000A47, 1'b1);
		expectReg(RegWrCount, '1, csrDataT'(expWrBursts), "RegWrCount");
		expectReg(RegRdCount, '1, csrDataT'(expRdBursts), "RegRdCount");

		$display(">>> PASS");
		$finish;
	end

endmodule

/* tests/psramModel.sv */
// Behavioural PSRAM pin model
// Command and address capture, strobed write data
// Fixed read wait, then eight words with strobes high
`timescale 1ns/10ps
module psramModel
	import psramPkg::*;
(
	input  logic       psramClk,
	input  logic       psramCsN,
	inout  wire [15:0] psramDq,
	inout  wire [1:0]  psramDqs
);

	localparam int MemDepth  = 4096;                 // Words kept, address wraps
	localparam int FirstData = 3;                    // Command plus two address words
	localparam int FirstRead = FirstData + ReadWait;

	psramDataT mem [MemDepth];
	psramDataT cmdWord   = '0;
	psramAddrT baseAddr  = '0;
	int        edgeIdx   = 0;       // Rising edges since chip select fell
	logic      driveEn   = 1'b0;
	psramDataT driveData = '0;

	assign psramDq  = driveEn ? driveData : 'z;
	assign psramDqs = driveEn ? 2'b11 : 2'bzz;      // Strobes only on valid read words

	function automatic int memIdx(input int beat);
		return (int'(baseAddr) + beat) % MemDepth;
	endfunction

	// ------------------------------------------------
	// Sampling on the rising pin clock
	// ------------------------------------------------
	always @(posedge psramClk)
	begin
		if (psramCsN)
			edgeIdx <= 0;                          // Idle clock between commands
		else
		begin
			edgeIdx <= edgeIdx + 1;
			case (edgeIdx)
				0: cmdWord <= psramDq;
				1: baseAddr[23:16] <= psramDq[7:0];
				2: baseAddr[15:0] <= psramDq;
				default:
				begin
					if (cmdWord == CmdWrite && psramDqs == 2'b11
						&& edgeIdx < FirstData + BurstLen)
						mem[memIdx(edgeIdx - FirstData)] <= psramDq;
				end
			endcase
		end
	end

	// Read words launch on the falling edge, ahead of the sample
	always @(negedge psramClk)
	begin
		if (cmdWord == CmdRead && edgeIdx >= FirstRead && edgeIdx < FirstRead + BurstLen)
		begin
			driveEn   <= 1'b1;
			driveData <= mem[memIdx(edgeIdx - FirstRead)];
		end
		else
			driveEn <= 1'b0;                       // Bus back to the controller
	end

endmodule
